// File: adpcm_a_trace.txt
// one 48-bit hex word per op, op code in the top digit
// 1: ROM byte [27:8] addr [7:0] data   2: host write [15:8] addr [7:0] data
// 3: frame-aligned key write   4: expect [43:32] index [31:16] left [15:0] right
// 5: test id   6: [43:32] ROM reads [19:0] last address   7: [15:8] stalls [7:0] writes
// 8: idle samples   F: end
100000010077 10000001017F 100000010277
100000020077 100000020177 100000020277
200000003001 200000003800 200000004001 200000004800
200000003102 200000003900 200000004102 200000004900
200000003202 200000003A00 200000004202 200000004A00
200000003301 200000003B00 200000004301 200000004B00
500000000002 200000002080 200000001000 300000000081
400001E00000 400106300000 400210800000 4003F8100000
200000000001 800000000004
500000000003 2000000020C4 200000001004 300000000081
400000F000F0 400103180318 400208400840 4003FC08FC08
200000000001 200000001000 800000000004
500000000004 200000002080 300000000081 400001E00000
420000000000 420100000000 420200000000 420300000000
6100000001FF 800000000002
500000000005 2000000021C0 200000002280 2000000023C0 30000000008E
400005A003C0 400112900C60 400231802100 400349F02100
40047FFF7FFF 40057FFF7FFF 20000000000E 800000000004
500000000006 200000002080 200000002140 300000000081 200000000082
400001E00000 4001063001E0 400210800630 4003F8101080
700000000104 200000000003 800000000004
F00000000000

// File: compile.f
+incdir+.
adpcm_a_pkg.sv
adpcm_a_regs.sv
adpcm_a_addr_cnt.sv
adpcm_a_decoder.sv
adpcm_a_gain.sv
adpcm_a_acc.sv
adpcm_a_top.sv
tb_adpcm_a.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adpcm_a
RTL_TOP   ?= adpcm_a_top
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIMFLAGS  ?= -Wno-fatal

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_adpcm_a.sv
// ADPCM-A playback testbench
// replays the trace file of ROM image, host writes and expected stereo samples
`timescale 1ns/1ns

module tb_adpcm_a;

    logic              clk, rst_n, cen, wr_valid, wr_ready, rom_oe_n, sample_valid;
    logic [7:0]        wr_addr, wr_data, rom_data;
    logic [19:0]       rom_addr, rd_max;
    adpcm_a_pkg::pcm_t pcm_l, pcm_r;

    logic [7:0]  rom    [0:1048575];
    logic [47:0] trace  [0:255];          // op in [47:44]
    logic [15:0] got_l  [0:4095];         // every published sample in order
    logic [15:0] got_r  [0:4095];
    integer      seed = 32'h32e46f25;
    int          cen_cnt = 0;
    int          n_smp = 0;
    int          cycles = 0;
    int          limit = 0;               // 0 until the trace is sized
    int          rd_cnt, hs_cnt, stall_cnt, base, test_err, err_total, n_tests, n_failed;
    string       cur_name = "";

    adpcm_a_top i_adpcm_a_top (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen          ( cen          ),
        .wr_valid     ( wr_valid     ),
        .wr_addr      ( wr_addr      ),
        .wr_data      ( wr_data      ),
        .rom_data     ( rom_data     ),
        .wr_ready     ( wr_ready     ),
        .rom_addr     ( rom_addr     ),
        .rom_oe_n     ( rom_oe_n     ),
        .pcm_l        ( pcm_l        ),
        .pcm_r        ( pcm_r        ),
        .sample_valid ( sample_valid )
    );

    assign rom_data = rom_oe_n ? 8'h00 : rom[rom_addr];   // sample ROM model

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #10;
        cen = (cen_cnt == 3);             // one clock in four
        cen_cnt = (cen_cnt + 1) % 4;
    end

    // outputs and ROM reads sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (sample_valid) begin
                got_l[n_smp] = pcm_l;
                got_r[n_smp] = pcm_r;
                n_smp++;
            end
            if (cen && !rom_oe_n) begin
                rd_cnt++;                 // one per fetch visit
                if (rom_addr > rd_max) rd_max = rom_addr;
            end
            if (wr_valid && wr_ready) hs_cnt++;   // write taken on the next edge
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, expected samples never arrived", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: %s expected %h actual %h", cur_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic realign_to_drive();
        @(posedge clk);
        #10;
    endtask

    task automatic close_test();
        if (cur_name != "") begin
            n_tests++;
            err_total += test_err;
            if (test_err != 0) begin
                n_failed++;
                $display("test %s: %0d mismatches", cur_name, test_err);
            end else begin
                $display("test %s: ok", cur_name);
            end
        end
        test_err = 0;
    endtask

    task automatic open_test(input string name);
        close_test();
        cur_name  = name;
        rd_cnt    = 0;
        rd_max    = '0;
        hs_cnt    = 0;
        stall_cnt = 0;
        base      = 0;
    endtask

    // valid after a random gap and held until the DUT takes it
    task automatic host_write(input logic [7:0] a, input logic [7:0] d);
        int gap;
        bit waited;
        gap = {$random(seed)} % 3;
        waited = 0;
        repeat (gap) realign_to_drive();
        wr_addr  = a;
        wr_data  = d;
        wr_valid = 1'b1;
        @(negedge clk);
        while (!wr_ready) begin
            waited = 1;
            @(negedge clk);
        end
        realign_to_drive();                // handshake on this edge
        wr_valid = 1'b0;
        if (waited) stall_cnt++;
    endtask

    // key command at a frame start with samples counted from here
    task automatic key_aligned(input logic [7:0] a, input logic [7:0] d);
        @(negedge clk);
        while (!sample_valid) @(negedge clk);
        realign_to_drive();
        host_write(a, d);
        base = n_smp;
    endtask

    function automatic string name_of(input logic [3:0] id);
        case (id)
            4'd2:    return "single channel left";
            4'd3:    return "pan and attenuation";
            4'd4:    return "end block";
            4'd5:    return "three channel mix";
            4'd6:    return "write back-pressure";
            default: return "unnamed";
        endcase
    endfunction

    initial begin
        int          pc, k, cur, frames;
        logic [47:0] w;
        rst_n    = 1'b0;
        cen      = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        for (int a = 0; a < 1048576; a++) rom[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
        for (int i = 0; i < 256; i++) trace[i] = 48'hF00000000000;
        $readmemh("adpcm_a_trace.txt", trace);
        // frame budget from the trace at 24 clocks per frame
        frames = 20;
        cur = 0;
        for (int i = 0; i < 256; i++) begin
            case (trace[i][47:44])
                4'h2: frames += 1;
                4'h3: frames += 6;
                4'h4: if (int'(trace[i][43:32]) + 1 > cur) begin
                          frames += int'(trace[i][43:32]) + 1 - cur;
                          cur = int'(trace[i][43:32]) + 1;
                      end
                4'h5: cur = 0;
                4'h8: frames += int'(trace[i][15:0]);
                default: ;
            endcase
        end
        limit = frames * 24 + 500;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;

        open_test("reset state");
        @(negedge clk);
        check("rom_oe_n", 32'd1, 32'(rom_oe_n));
        check("wr_ready", 32'd1, 32'(wr_ready));
        check("sample_valid", 32'd0, 32'(sample_valid));
        check("pcm_l", 32'd0, 32'(pcm_l));
        check("pcm_r", 32'd0, 32'(pcm_r));
        check("rom_addr", 32'd0, 32'(rom_addr));
        k = n_smp;
        while (n_smp < k + 3) @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            check("idle left", 32'd0, 32'(got_l[k+i]));
            check("idle right", 32'd0, 32'(got_r[k+i]));
        end
        realign_to_drive();

        pc = 0;
        while (trace[pc][47:44] != 4'hF) begin
            w = trace[pc];
            case (w[47:44])
                4'h1: rom[w[27:8]] = w[7:0];
                4'h2: host_write(w[15:8], w[7:0]);
                4'h3: key_aligned(w[15:8], w[7:0]);
                4'h4: begin
                    k = base + 4 + int'(w[43:32]);     // first nibble 3 frames after key-on
                    while (n_smp <= k) @(negedge clk);
                    check($sformatf("sample %0d left", w[43:32]), 32'(w[31:16]), 32'(got_l[k]));
                    check($sformatf("sample %0d right", w[43:32]), 32'(w[15:0]), 32'(got_r[k]));
                    realign_to_drive();
                end
                4'h5: open_test(name_of(w[3:0]));
                4'h6: begin
                    check("ROM reads", 32'(w[43:32]), 32'(rd_cnt));
                    check("last ROM address", 32'(w[19:0]), 32'(rd_max));
                end
                4'h7: begin
                    check("handshakes", 32'(w[7:0]), 32'(hs_cnt));
                    check("stalled writes", 32'(w[15:8]), 32'(stall_cnt));
                end
                4'h8: begin
                    k = n_smp + int'(w[15:0]);
                    while (n_smp < k) @(negedge clk);
                    realign_to_drive();
                end
                default: begin
                    $display("trace word %0d has an unknown opcode %h", pc, w[47:44]);
                    test_err++;
                end
            endcase
            pc++;
        end
        close_test();
        $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, err_total);
        if (err_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: adpcm_a_top.sv
// ADPCM-A playback top
// six time-shared sample channels mixed into one stereo sample per frame
// first nibble of a key-on reaches the output three frames later
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     wr_valid,
    input  logic [7:0]               wr_addr,
    input  logic [7:0]               wr_data,
    input  logic [7:0]               rom_data,
    output logic                     wr_ready,
    output logic [`ADPCM_A_AW-1:0]   rom_addr,
    output logic                     rom_oe_n,
    output adpcm_a_pkg::pcm_t        pcm_l,
    output adpcm_a_pkg::pcm_t        pcm_r,
    output logic                     sample_valid
);

    adpcm_a_pkg::ch_t        slot;
    logic                    key_on, key_off;
    logic [`ADPCM_A_BW-1:0]  start_blk, end_blk;
    logic [7:0]              lrl;
    logic [`ADPCM_A_TLW-1:0] tl;
    logic [3:0]              nib;
    logic                    nib_en, dec_en;
    adpcm_a_pkg::pcm_t       pcm_dec, ch_l, ch_r;

    adpcm_a_regs u_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen       ( cen       ),
        .wr_valid  ( wr_valid  ),
        .wr_addr   ( wr_addr   ),
        .wr_data   ( wr_data   ),
        .wr_ready  ( wr_ready  ),
        .slot      ( slot      ),
        .key_on    ( key_on    ),
        .key_off   ( key_off   ),
        .start_blk ( start_blk ),
        .end_blk   ( end_blk   ),
        .lrl       ( lrl       ),
        .tl        ( tl        )
    );

    adpcm_a_addr_cnt u_cnt (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen       ( cen       ),
        .key_on    ( key_on    ),
        .key_off   ( key_off   ),
        .start_blk ( start_blk ),
        .end_blk   ( end_blk   ),
        .rom_data  ( rom_data  ),
        .rom_addr  ( rom_addr  ),
        .rom_oe_n  ( rom_oe_n  ),
        .nib       ( nib       ),
        .nib_en    ( nib_en    )
    );

    adpcm_a_decoder u_decoder (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen     ( cen     ),
        .key_on  ( key_on  ),
        .nib     ( nib     ),
        .nib_en  ( nib_en  ),
        .pcm_dec ( pcm_dec ),
        .dec_en  ( dec_en  )
    );

    adpcm_a_gain u_gain (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen     ( cen     ),
        .pcm_dec ( pcm_dec ),
        .dec_en  ( dec_en  ),
        .lrl     ( lrl     ),
        .tl      ( tl      ),
        .ch_l    ( ch_l    ),
        .ch_r    ( ch_r    )
    );

    adpcm_a_acc u_acc_l (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen          ( cen          ),
        .slot         ( slot         ),
        .pcm_in       ( ch_l         ),
        .pcm_out      ( pcm_l        ),
        .sample_valid ( sample_valid )
    );

    // same timing as the left side
    adpcm_a_acc u_acc_r (
        .clk          ( clk   ),
        .rst_n        ( rst_n ),
        .cen          ( cen   ),
        .slot         ( slot  ),
        .pcm_in       ( ch_r  ),
        .pcm_out      ( pcm_r ),
        .sample_valid (       )
    );

endmodule

// File: adpcm_a_acc.sv
// ADPCM-A frame mixer
// adds six slot values and publishes the clamped total once per frame
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_acc (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  adpcm_a_pkg::ch_t   slot,
    input  adpcm_a_pkg::pcm_t  pcm_in,
    output adpcm_a_pkg::pcm_t  pcm_out,
    output logic               sample_valid
);

    logic signed [18:0] sum_q, total;     // room for six full-scale values
    adpcm_a_pkg::pcm_t  sat;

    assign total = sum_q + pcm_in;

    always_comb begin
        if (total > 19'sd32767)       sat = 16'sh7fff;
        else if (total < -19'sd32768) sat = 16'sh8000;
        else                          sat = total[15:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q        <= '0;
            pcm_out      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (cen) begin
                if (slot == adpcm_a_pkg::ch_t'(`ADPCM_A_NCH - 1)) begin
                    pcm_out      <= sat;        // frame closes into slot 0
                    sum_q        <= '0;
                    sample_valid <= 1'b1;
                end else begin
                    sum_q <= total;
                end
            end
        end
    end

endmodule

// File: adpcm_a_gain.sv
// ADPCM-A channel gain and panning
// attenuation table lookup, multiply and left/right routing, one slot latency
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_gain (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  adpcm_a_pkg::pcm_t        pcm_dec,
    input  logic                     dec_en,
    input  logic [7:0]               lrl,
    input  logic [`ADPCM_A_TLW-1:0]  tl,
    output adpcm_a_pkg::pcm_t        ch_l,
    output adpcm_a_pkg::pcm_t        ch_r
);

    logic [7:0]              lrl_d;   // lines up with the decoder output
    logic [`ADPCM_A_TLW-1:0] tl_d;
    logic [6:0]              att;
    logic [8:0]              mul;
    logic signed [25:0]      prod;
    adpcm_a_pkg::pcm_t       scaled;

    assign att    = lrl_d[`ADPCM_A_LVLW-1:0] + tl_d;
    assign mul    = 9'(adpcm_a_pkg::level_mul[att > 7'd63 ? 6'd63 : att[5:0]]);
    assign prod   = pcm_dec * $signed({1'b0, mul});
    assign scaled = prod[23:8];       // drop the 8 fraction bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lrl_d <= '0;
            tl_d  <= '0;
            ch_l  <= '0;
            ch_r  <= '0;
        end else if (cen) begin
            lrl_d <= lrl;
            tl_d  <= tl;
            ch_l  <= (dec_en && lrl_d[7]) ? scaled : '0;   // left pan
            ch_r  <= (dec_en && lrl_d[6]) ? scaled : '0;   // right pan
        end
    end

endmodule

// File: adpcm_a_decoder.sv
// ADPCM-A nibble decoder
// rotating accumulator and step index per channel, one slot of latency
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               key_on,
    input  logic [3:0]         nib,
    input  logic               nib_en,
    output adpcm_a_pkg::pcm_t  pcm_dec,
    output logic               dec_en
);

    logic signed [11:0] acc_q [`ADPCM_A_NCH];   // entry 0 is the current slot
    logic [5:0]         idx_q [`ADPCM_A_NCH];
    logic [10:0]        step;
    logic [14:0]        prod;
    logic signed [13:0] dmag, acc_w;
    logic signed [11:0] acc_c;
    logic [5:0]         idx_c;
    int                 idx_w;

    always_comb begin
        step  = 11'(adpcm_a_pkg::step_table[idx_q[0]]);
        prod  = {nib[2:0], 1'b1} * step;          // (2m+1) * step
        dmag  = {2'b00, prod[14:3]};              // divide by 8
        acc_w = nib[3] ? acc_q[0] - dmag : acc_q[0] + dmag;
        if (acc_w > 14'sd2047)       acc_c = 12'sh7ff;
        else if (acc_w < -14'sd2048) acc_c = 12'sh800;
        else                         acc_c = acc_w[11:0];
        idx_w = int'(idx_q[0]) + adpcm_a_pkg::index_adj[nib[2:0]];
        if (idx_w < 0)                         idx_c = '0;
        else if (idx_w > `ADPCM_A_STEPS - 1)   idx_c = 6'(`ADPCM_A_STEPS - 1);
        else                                   idx_c = 6'(idx_w);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= '{default: '0};
            idx_q   <= '{default: '0};
            pcm_dec <= '0;
            dec_en  <= 1'b0;
        end else if (cen) begin
            for (int i = 0; i < `ADPCM_A_NCH - 1; i++) begin
                acc_q[i] <= acc_q[i+1];
                idx_q[i] <= idx_q[i+1];
            end
            if (key_on) begin
                acc_q[`ADPCM_A_NCH-1] <= '0;     // fresh sample
                idx_q[`ADPCM_A_NCH-1] <= '0;
            end else if (nib_en) begin
                acc_q[`ADPCM_A_NCH-1] <= acc_c;
                idx_q[`ADPCM_A_NCH-1] <= idx_c;
            end else begin
                acc_q[`ADPCM_A_NCH-1] <= acc_q[0];
                idx_q[`ADPCM_A_NCH-1] <= idx_q[0];
            end
            // silent slots give 0
            pcm_dec <= (nib_en && !key_on) ? {acc_c, 4'b0000} : '0;
            dec_en  <= nib_en && !key_on;
        end
    end

endmodule

// File: adpcm_a_addr_cnt.sv
// ADPCM-A ROM address counters
// one rotating entry per channel; fetches a byte every second visit
// and hands one nibble per visit to the decoder, high nibble first
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_addr_cnt (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen,
    input  logic                    key_on,
    input  logic                    key_off,
    input  logic [`ADPCM_A_BW-1:0]  start_blk,
    input  logic [`ADPCM_A_BW-1:0]  end_blk,
    input  logic [7:0]              rom_data,
    output logic [`ADPCM_A_AW-1:0]  rom_addr,
    output logic                    rom_oe_n,
    output logic [3:0]              nib,
    output logic                    nib_en
);

    // entry 0 belongs to the current slot
    logic [`ADPCM_A_AW-1:0] addr_q  [`ADPCM_A_NCH];
    logic [7:0]             byte_q  [`ADPCM_A_NCH];
    logic                   nib_sel [`ADPCM_A_NCH];   // 1: high nibble of byte_q is due
    logic                   play_q  [`ADPCM_A_NCH];
    logic                   arm_q   [`ADPCM_A_NCH];   // keyed, address loads next visit
    logic                   vld_q   [`ADPCM_A_NCH];   // a nibble is due this visit
    logic [`ADPCM_A_AW-1:0] addr_n;
    logic [7:0]             byte_n;
    logic                   sel_n, play_n, arm_n, vld_n, last;

    always_comb begin
        addr_n = addr_q[0];
        byte_n = byte_q[0];
        sel_n  = nib_sel[0];
        play_n = play_q[0];
        arm_n  = arm_q[0];
        vld_n  = 1'b0;
        last   = addr_q[0] == {end_blk, 8'hff};
        if (key_on) begin
            arm_n  = 1'b1;
            play_n = 1'b0;
        end else if (key_off) begin
            arm_n  = 1'b0;
            play_n = 1'b0;
        end else if (arm_q[0]) begin
            arm_n  = 1'b0;
            play_n = 1'b1;
            sel_n  = 1'b0;
            addr_n = {start_blk, 8'h00};
        end else if (play_q[0]) begin
            vld_n = 1'b1;
            if (!nib_sel[0]) begin
                byte_n = rom_data;       // ROM answered this visit
                sel_n  = 1'b1;
            end else begin
                sel_n = 1'b0;            // low nibble next visit
                if (last) play_n = 1'b0; // address stays inside the end block
                else      addr_n = addr_q[0] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '{default: '0};
            byte_q  <= '{default: '0};
            nib_sel <= '{default: 1'b0};
            play_q  <= '{default: 1'b0};
            arm_q   <= '{default: 1'b0};
            vld_q   <= '{default: 1'b0};
        end else if (cen) begin
            for (int i = 0; i < `ADPCM_A_NCH - 1; i++) begin
                addr_q[i]  <= addr_q[i+1];
                byte_q[i]  <= byte_q[i+1];
                nib_sel[i] <= nib_sel[i+1];
                play_q[i]  <= play_q[i+1];
                arm_q[i]   <= arm_q[i+1];
                vld_q[i]   <= vld_q[i+1];
            end
            addr_q[`ADPCM_A_NCH-1]  <= addr_n;
            byte_q[`ADPCM_A_NCH-1]  <= byte_n;
            nib_sel[`ADPCM_A_NCH-1] <= sel_n;
            play_q[`ADPCM_A_NCH-1]  <= play_n;
            arm_q[`ADPCM_A_NCH-1]   <= arm_n;
            vld_q[`ADPCM_A_NCH-1]   <= vld_n;
        end
    end

    assign rom_addr = addr_q[0];
    assign rom_oe_n = !(play_q[0] && !nib_sel[0]);    // read on fetch visits only
    assign nib      = nib_sel[0] ? byte_q[0][7:4] : byte_q[0][3:0];
    assign nib_en   = vld_q[0];

endmodule

// File: adpcm_a_regs.sv
// ADPCM-A host registers and slot sequencer
// takes host writes, runs the slot counter and the key on/off shifters,
// presents the registers of the current slot
`timescale 1ns/1ns
`include "adpcm_a_settings.svh"

module adpcm_a_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen,
    input  logic                      wr_valid,
    input  logic [7:0]                wr_addr,
    input  logic [7:0]                wr_data,
    output logic                      wr_ready,
    output adpcm_a_pkg::ch_t          slot,
    output logic                      key_on,
    output logic                      key_off,
    output logic [`ADPCM_A_BW-1:0]    start_blk,
    output logic [`ADPCM_A_BW-1:0]    end_blk,
    output logic [7:0]                lrl,
    output logic [`ADPCM_A_TLW-1:0]   tl
);

    logic [`ADPCM_A_BW-1:0]  start_r [`ADPCM_A_NCH];
    logic [`ADPCM_A_BW-1:0]  end_r   [`ADPCM_A_NCH];
    logic [7:0]              lrl_r   [`ADPCM_A_NCH];
    logic [`ADPCM_A_NCH-1:0] on_sr, off_sr;    // bit 0 is the current slot
    logic [7:0]              key_cmd;
    logic                    key_pend;         // key command waits for slot 0
    adpcm_a_pkg::reg_sel_t   wr_sel;
    adpcm_a_pkg::ch_t        wr_ch;
    logic                    wr_fire, wr_hi, ch_ok, frame_end;

    assign wr_sel    = adpcm_a_pkg::reg_sel_t'(wr_addr[7:4]);
    assign wr_hi     = wr_addr[3];
    assign wr_ch     = wr_addr[2:0];
    assign ch_ok     = wr_ch < `ADPCM_A_NCH;
    assign wr_ready  = !key_pend;
    assign wr_fire   = wr_valid & wr_ready;
    assign frame_end = cen && slot == adpcm_a_pkg::ch_t'(`ADPCM_A_NCH - 1);

    // block numbers, written in two bytes
    always_ff @(posedge clk) begin
        if (wr_fire && ch_ok) begin
            if (wr_sel == adpcm_a_pkg::SEL_START) begin
                if (wr_hi) start_r[wr_ch][`ADPCM_A_BW-1:8] <= wr_data[`ADPCM_A_BW-9:0];
                else       start_r[wr_ch][7:0] <= wr_data;
            end
            if (wr_sel == adpcm_a_pkg::SEL_END) begin
                if (wr_hi) end_r[wr_ch][`ADPCM_A_BW-1:8] <= wr_data[`ADPCM_A_BW-9:0];
                else       end_r[wr_ch][7:0] <= wr_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            key_pend <= 1'b0;
            key_cmd  <= '0;
            on_sr    <= '0;
            off_sr   <= '0;
            lrl_r    <= '{default: '0};
            tl       <= '0;
        end else begin
            if (wr_fire) begin
                case (wr_sel)
                    adpcm_a_pkg::SEL_KEY: begin
                        key_cmd  <= wr_data;
                        key_pend <= 1'b1;      // held off until the frame turns
                    end
                    adpcm_a_pkg::SEL_TL:  tl <= wr_data[`ADPCM_A_TLW-1:0];
                    adpcm_a_pkg::SEL_LRL: if (ch_ok) lrl_r[wr_ch] <= wr_data;
                    default: ;
                endcase
            end
            if (cen) begin
                slot <= frame_end ? '0 : slot + 1'b1;
                if (frame_end && key_pend) begin
                    // mask lands so that bit n meets slot n
                    on_sr    <= key_cmd[7] ? key_cmd[`ADPCM_A_NCH-1:0] : '0;
                    off_sr   <= key_cmd[7] ? '0 : key_cmd[`ADPCM_A_NCH-1:0];
                    key_pend <= 1'b0;
                end else begin
                    on_sr    <= {1'b0, on_sr[`ADPCM_A_NCH-1:1]};    // one pulse per channel
                    off_sr   <= {1'b0, off_sr[`ADPCM_A_NCH-1:1]};
                end
            end
        end
    end

    assign key_on    = on_sr[0];
    assign key_off   = off_sr[0];
    assign start_blk = start_r[slot];
    assign end_blk   = end_r[slot];
    assign lrl       = lrl_r[slot];

endmodule

// File: adpcm_a_pkg.sv
// ADPCM-A shared types, host register codes and lookup tables
`include "adpcm_a_settings.svh"

package adpcm_a_pkg;

    typedef logic [2:0] ch_t;             // slot number 0..5
    typedef logic signed [15:0] pcm_t;

    // host address: [7:4] register code, [3] block high byte, [2:0] channel
    typedef enum logic [3:0] {
        SEL_KEY   = 4'h0,   // [7] on/off, [5:0] channel mask
        SEL_TL    = 4'h1,   // total attenuation
        SEL_LRL   = 4'h2,   // [7] left, [6] right, [4:0] attenuation
        SEL_START = 4'h3,
        SEL_END   = 4'h4
    } reg_sel_t;

    localparam int step_table [`ADPCM_A_STEPS] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307,
        337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411,
        1552
    };

    localparam int index_adj [8] = '{-1, -1, -1, -1, 2, 5, 7, 9};

    // 0.75 dB per step, 256 is unity
    localparam int level_mul [`ADPCM_A_LVLS] = '{
        256, 235, 215, 197, 181, 166, 152, 140,
        128, 117, 108, 99, 90, 83, 76, 70,
        64, 59, 54, 49, 45, 42, 38, 35,
        32, 29, 27, 25, 23, 21, 19, 17,
        16, 15, 13, 12, 11, 10, 10, 9,
        8, 7, 7, 6, 6, 5, 5, 4,
        4, 4, 3, 3, 3, 3, 2, 2,
        2, 2, 2, 2, 1, 1, 1, 1
    };

endpackage

// File: adpcm_a_settings.svh
// ADPCM-A sizing constants
// channel slots, ROM address split, table depths and level widths
`ifndef ADPCM_A_SETTINGS_SVH
`define ADPCM_A_SETTINGS_SVH

`define ADPCM_A_NCH   6     // channel slots per frame
`define ADPCM_A_AW    20    // ROM byte address
`define ADPCM_A_BW    12    // block number, 256 bytes per block
`define ADPCM_A_LVLW  5     // channel attenuation field
`define ADPCM_A_TLW   6     // total attenuation
`define ADPCM_A_STEPS 49    // step table depth
`define ADPCM_A_LVLS  64    // gain table depth

`endif
